//--- batchFilterTop.f
hdl/batchPkg.sv
hdl/batchSequencer.sv
hdl/batchMemory.sv
hdl/recursionStage.sv
hdl/calcChannel.sv
hdl/batchFilterTop.sv
sim/batchFilterChecker.sv
sim/batchFilterTb.sv

//--- hdl/batchFilterTop.sv
`timescale 1ns/1ps

module batchFilterTop #(
    parameter int N = 3,
    parameter int depth = 16
) (
    input  logic             clkDS,
    input  logic             rst,
    input  logic [N-1:0]     ctrlIn,
    output batchPkg::fixT    out,
    output logic             outValid
);
    import batchPkg::*;

    localparam int sampleAw = $clog2(4*depth);
    localparam int resAw = $clog2(2*depth);

    logic [sampleAw-1:0] wrAddr, lhAddr, bwdAddr, fwdAddr;
    logic [resAw-1:0] resWrAddr, resBwdAddr, resFwdAddr;
    logic restartN;

    // Read ports 0..2 are lookahead, backward, forward
    logic [sampleAw-1:0] sampleRdAddr [3];
    logic [N-1:0] sampleRd [3];

    logic [resAw-1:0] resFwdRdAddr [1];
    logic [resAw-1:0] resBwdRdAddr [1];
    fixT resFwdRd [1];
    fixT resBwdRd [1];

    fixT fwdPart [N];
    fixT bwdPart [N];
    fixT fwdChain [N];
    fixT bwdChain [N];

    batchSequencer #(.depth(depth)) sequencer (
        .clkDS      (clkDS),
        .rst        (rst),
        .wrAddr     (wrAddr),
        .lhAddr     (lhAddr),
        .bwdAddr    (bwdAddr),
        .fwdAddr    (fwdAddr),
        .resWrAddr  (resWrAddr),
        .resBwdAddr (resBwdAddr),
        .resFwdAddr (resFwdAddr),
        .restartN   (restartN),
        .outValid   (outValid)
    );

    assign sampleRdAddr[0] = lhAddr;
    assign sampleRdAddr[1] = bwdAddr;
    assign sampleRdAddr[2] = fwdAddr;

    // Four batch slots of raw control words
    batchMemory #(.dataT(logic [N-1:0]), .entries(4*depth), .readPorts(3)) sampleMem (
        .clkDS  (clkDS),
        .wrAddr (wrAddr),
        .wrData (ctrlIn),
        .rdAddr (sampleRdAddr),
        .rdData (sampleRd)
    );

    for (genvar i = 0; i < N; i++) begin : channels
        calcChannel #(.channel(i), .N(N)) chan (
            .clkDS    (clkDS),
            .rst      (rst),
            .restartN (restartN),
            .lhBits   (sampleRd[0]),
            .bwdBits  (sampleRd[1]),
            .fwdBits  (sampleRd[2]),
            .fwdPart  (fwdPart[i]),
            .bwdPart  (bwdPart[i])
        );

        // Adder chain across channels, wraps at dataWidth
        if (i == 0) begin : chainStart
            assign fwdChain[0] = fwdPart[0];
            assign bwdChain[0] = bwdPart[0];
        end else begin : chainAdd
            assign fwdChain[i] = fwdChain[i-1] + fwdPart[i];
            assign bwdChain[i] = bwdChain[i-1] + bwdPart[i];
        end
    end

    assign resFwdRdAddr[0] = resFwdAddr;
    assign resBwdRdAddr[0] = resBwdAddr;

    // Two halves each, one being written while the other is read
    batchMemory #(.dataT(fixT), .entries(2*depth), .readPorts(1)) resFwdMem (
        .clkDS  (clkDS),
        .wrAddr (resWrAddr),
        .wrData (fwdChain[N-1]),
        .rdAddr (resFwdRdAddr),
        .rdData (resFwdRd)
    );

    // Backward sums arrive reversed and are read back reversed
    batchMemory #(.dataT(fixT), .entries(2*depth), .readPorts(1)) resBwdMem (
        .clkDS  (clkDS),
        .wrAddr (resWrAddr),
        .wrData (bwdChain[N-1]),
        .rdAddr (resBwdRdAddr),
        .rdData (resBwdRd)
    );

    always_ff @(posedge clkDS) begin
        out <= resFwdRd[0] + resBwdRd[0];
    end

endmodule

//--- hdl/batchMemory.sv
`timescale 1ns/1ps

module batchMemory #(
    parameter type dataT = logic,
    parameter int entries = 16,
    parameter int readPorts = 1
) (
    input  logic                          clkDS,
    input  logic [$clog2(entries)-1:0]    wrAddr,
    input  dataT                          wrData,
    input  logic [$clog2(entries)-1:0]    rdAddr [readPorts],
    output dataT                          rdData [readPorts]
);
    dataT mem [entries];

    // Written every cycle, the stream never pauses
    always_ff @(posedge clkDS) begin
        mem[wrAddr] <= wrData;
    end

    // Registered reads, old data on a same-address collision
    always_ff @(posedge clkDS) begin
        for (int p = 0; p < readPorts; p++) begin
            rdData[p] <= mem[rdAddr[p]];
        end
    end

endmodule

//--- hdl/batchPkg.sv
package batchPkg;

    // Signed fixed point, 4 integer bits and 14 fraction bits
    localparam int dataWidth = 18;
    localparam int fracBits = 14;
    localparam int maxChannels = 4;

    typedef logic signed [dataWidth-1:0] fixT;

    typedef struct packed {
        fixT re;
        fixT im;
    } complexT;

    // Pole factors per channel
    localparam complexT lambdaF [maxChannels] = '{
        '{15565, 3277}, '{14746, -4915}, '{13107, 6554}, '{12288, 0}
    };
    localparam complexT lambdaB [maxChannels] = '{
        '{15565, -3277}, '{14746, 4915}, '{13107, -6554}, '{12288, 0}
    };

    // Output weights per channel
    localparam complexT weightF [maxChannels] = '{
        '{4096, 1024}, '{3277, -2048}, '{2458, 819}, '{1638, 0}
    };
    localparam complexT weightB [maxChannels] = '{
        '{4096, -1024}, '{3277, 2048}, '{2458, -819}, '{1638, 0}
    };

    // Contribution of each control bit, rows by channel and columns by bit
    localparam complexT ctrlF [maxChannels][maxChannels] = '{
        '{'{512, 128}, '{384, -96}, '{256, 64}, '{192, 0}},
        '{'{448, -160}, '{320, 80}, '{224, -48}, '{160, 32}},
        '{'{400, 200}, '{288, -144}, '{208, 96}, '{144, -64}},
        '{'{480, 0}, '{352, 0}, '{240, 0}, '{176, 0}}
    };
    localparam complexT ctrlB [maxChannels][maxChannels] = '{
        '{'{480, -120}, '{360, 90}, '{240, -60}, '{180, 0}},
        '{'{420, 150}, '{300, -75}, '{210, 45}, '{150, -30}},
        '{'{380, -190}, '{270, 135}, '{190, -95}, '{135, 60}},
        '{'{460, 0}, '{340, 0}, '{230, 0}, '{170, 0}}
    };

    // Product truncated by an arithmetic shift, result wraps at dataWidth
    function automatic fixT fixMul(input fixT a, input fixT b);
        logic signed [2*dataWidth-1:0] prod;
        prod = a * b;
        return fixT'(prod >>> fracBits);
    endfunction

    // Each partial product is truncated on its own before the sum
    function automatic complexT cMul(input complexT a, input complexT b);
        complexT r;
        r.re = fixMul(a.re, b.re) - fixMul(a.im, b.im);
        r.im = fixMul(a.re, b.im) + fixMul(a.im, b.re);
        return r;
    endfunction

    function automatic complexT cAdd(input complexT a, input complexT b);
        complexT r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

endpackage

//--- hdl/batchSequencer.sv
`timescale 1ns/1ps

module batchSequencer #(
    parameter int depth = 16
) (
    input  logic                          clkDS,
    input  logic                          rst,
    output logic [$clog2(4*depth)-1:0]    wrAddr,
    output logic [$clog2(4*depth)-1:0]    lhAddr,
    output logic [$clog2(4*depth)-1:0]    bwdAddr,
    output logic [$clog2(4*depth)-1:0]    fwdAddr,
    output logic [$clog2(2*depth)-1:0]    resWrAddr,
    output logic [$clog2(2*depth)-1:0]    resBwdAddr,
    output logic [$clog2(2*depth)-1:0]    resFwdAddr,
    output logic                          restartN,
    output logic                          outValid
);
    localparam int cntWidth = $clog2(depth);
    localparam int fillCycles = 3*depth + 5;

    logic [cntWidth-1:0] cnt, cntRev;
    logic [1:0] slot, lhSlot, calcSlot;
    logic lastSample;

    // Batch position and ping-pong half delayed to the channel outputs
    logic [cntWidth-1:0] cntD [3];
    logic [cntWidth-1:0] cntRevD [3];
    logic halfD [3];

    logic [$clog2(fillCycles)-1:0] fillCnt;

    assign lastSample = (cnt == cntWidth'(depth-1));

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            cnt <= '0;
            cntRev <= cntWidth'(depth-1);
            slot <= 2'd0;
            lhSlot <= 2'd3;
            calcSlot <= 2'd2;
            restartN <= 1'b1;
        end else begin
            // Slots rotate at the end of every batch
            if (lastSample) begin
                cnt <= '0;
                cntRev <= cntWidth'(depth-1);
                calcSlot <= lhSlot;
                lhSlot <= slot;
                slot <= slot + 2'd1;
            end else begin
                cnt <= cnt + 1'b1;
                cntRev <= cntRev - 1'b1;
            end
            // Lines up with the read data of the last sample
            restartN <= !lastSample;
        end
    end

    // Three stages to match the recursion and the two output registers
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            cntD <= '{default: '0};
            cntRevD <= '{default: '0};
            halfD <= '{default: 1'b0};
        end else begin
            cntD[0] <= cnt;
            cntD[1] <= cntD[0];
            cntD[2] <= cntD[1];
            cntRevD[0] <= cntRev;
            cntRevD[1] <= cntRevD[0];
            cntRevD[2] <= cntRevD[1];
            halfD[0] <= slot[0];
            halfD[1] <= halfD[0];
            halfD[2] <= halfD[1];
        end
    end

    // First output once batch zero has gone through both result passes
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fillCnt <= '0;
            outValid <= 1'b0;
        end else if (!outValid) begin
            fillCnt <= fillCnt + 1'b1;
            if (fillCnt == ($clog2(fillCycles))'(fillCycles-1)) begin
                outValid <= 1'b1;
            end
        end
    end

    assign wrAddr = {cnt, slot};
    assign lhAddr = {cntRev, lhSlot};
    assign bwdAddr = {cntRev, calcSlot};
    assign fwdAddr = {cnt, calcSlot};

    // Results of one batch are read back while the next one is written
    assign resWrAddr = {cntD[2], halfD[2]};
    assign resFwdAddr = {cntD[2], !halfD[2]};
    assign resBwdAddr = {cntRevD[2], !halfD[2]};

    slotsDistinct: assert property (@(posedge clkDS) disable iff (!rst)
        (slot != lhSlot) && (slot != calcSlot) && (lhSlot != calcSlot))
        else $error("write, lookahead and compute slots overlap");

endmodule

//--- hdl/calcChannel.sv
`timescale 1ns/1ps

module calcChannel #(
    parameter int channel = 0,
    parameter int N = 3
) (
    input  logic                 clkDS,
    input  logic                 rst,
    input  logic                 restartN,
    input  logic [N-1:0]         lhBits,
    input  logic [N-1:0]         bwdBits,
    input  logic [N-1:0]         fwdBits,
    output batchPkg::fixT        fwdPart,
    output batchPkg::fixT        bwdPart
);
    import batchPkg::*;

    complexT lhDrive, bwdDrive, fwdDrive;
    complexT lhState, bwdState, fwdState;
    complexT fwdHeld, bwdHeld;
    complexT fwdWeighted, bwdWeighted;

    // Lookup table, sum of the contributions of all set bits
    function automatic complexT bitSum(input logic [N-1:0] bits, input logic useFwd);
        complexT acc;
        complexT term;
        acc = '0;
        for (int b = 0; b < N; b++) begin
            term = useFwd ? ctrlF[channel][b] : ctrlB[channel][b];
            if (bits[b]) begin
                acc = cAdd(acc, term);
            end
        end
        return acc;
    endfunction

    assign lhDrive = bitSum(lhBits, 1'b0);
    assign bwdDrive = bitSum(bwdBits, 1'b0);
    assign fwdDrive = bitSum(fwdBits, 1'b1);

    // Lookahead warms up the backward state on the following batch
    recursionStage #(.pole(lambdaB[channel])) lhRec (
        .clkDS      (clkDS),
        .restartN   (restartN),
        .restartVal ('0),
        .drive      (lhDrive),
        .state      (lhState)
    );

    recursionStage #(.pole(lambdaB[channel])) bwdRec (
        .clkDS      (clkDS),
        .restartN   (restartN),
        .restartVal (lhState),
        .drive      (bwdDrive),
        .state      (bwdState)
    );

    recursionStage #(.pole(lambdaF[channel])) fwdRec (
        .clkDS      (clkDS),
        .restartN   (restartN),
        .restartVal ('0),
        .drive      (fwdDrive),
        .state      (fwdState)
    );

    // Only the real part survives the weighting
    assign fwdWeighted = cMul(weightF[channel], fwdHeld);
    assign bwdWeighted = cMul(weightB[channel], bwdHeld);

    // Register after the recursion, then after the weight product
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fwdHeld <= '0;
            bwdHeld <= '0;
            fwdPart <= '0;
            bwdPart <= '0;
        end else begin
            fwdHeld <= fwdState;
            bwdHeld <= bwdState;
            fwdPart <= fwdWeighted.re;
            bwdPart <= bwdWeighted.re;
        end
    end

endmodule

//--- hdl/recursionStage.sv
`timescale 1ns/1ps

module recursionStage #(
    parameter batchPkg::complexT pole = '0
) (
    input  logic                 clkDS,
    input  logic                 restartN,
    input  batchPkg::complexT    restartVal,
    input  batchPkg::complexT    drive,
    output batchPkg::complexT    state
);
    import batchPkg::*;

    complexT nextState;

    // First order step
    always_comb begin
        nextState = cAdd(cMul(pole, state), drive);
    end

    // Restart drops the drive of that cycle
    always_ff @(posedge clkDS) begin
        if (!restartN) begin
            state <= restartVal;
        end else begin
            state <= nextState;
        end
    end

    // One restart per batch, so never two cycles in a row
    singleRestart: assert property (@(posedge clkDS) !restartN |=> restartN)
        else $error("restartN held low for more than one cycle");

endmodule

//--- sim/batchFilterChecker.sv
`timescale 1ns/1ps

module batchFilterChecker #(
    parameter int N = 3,
    parameter int depth = 16,
    parameter int numBatches = 9
) (
    input  logic             clkDS,
    input  logic             rst,
    input  logic             outValid,
    input  batchPkg::fixT    out,
    input  logic [N-1:0]     samples [numBatches][depth],
    input  logic             useModel [numBatches],
    input  int               literalOut [numBatches],
    input  int               testOf [numBatches],
    input  logic             loaded,
    output logic             done,
    output int               failures
);
    import batchPkg::*;

    localparam int firstValid = 3*depth + 5;
    localparam int watchLimit = 500;

    typedef struct packed {
        int re;
        int im;
    } cplx;

    int expected [numBatches*depth];
    int testErrors [6];
    string testNames [6] = '{"", "reset and first valid", "zero stream",
                             "impulse response", "random stream", "valid without gaps"};

    // Keep the low 18 bits with sign extension
    function automatic int wrapFix(input longint v);
        logic signed [17:0] w;
        w = v[17:0];
        return int'(w);
    endfunction

    function automatic int truncMul(input int a, input int b);
        longint p;
        p = longint'(a) * longint'(b);
        return wrapFix(p >>> fracBits);
    endfunction

    function automatic cplx mulC(input cplx a, input cplx b);
        cplx r;
        r.re = wrapFix(truncMul(a.re, b.re) - truncMul(a.im, b.im));
        r.im = wrapFix(truncMul(a.re, b.im) + truncMul(a.im, b.re));
        return r;
    endfunction

    function automatic cplx toC(input complexT x);
        cplx r;
        r.re = int'(x.re);
        r.im = int'(x.im);
        return r;
    endfunction

    function automatic cplx step(input complexT pole, input cplx st, input cplx d);
        cplx r;
        r = mulC(toC(pole), st);
        r.re = wrapFix(r.re + d.re);
        r.im = wrapFix(r.im + d.im);
        return r;
    endfunction

    function automatic cplx driveOf(input int ch, input logic [N-1:0] bits, input bit useFwd);
        cplx acc;
        complexT c;
        acc = '0;
        for (int b = 0; b < N; b++) begin
            c = useFwd ? ctrlF[ch][b] : ctrlB[ch][b];
            if (bits[b]) begin
                acc.re = wrapFix(acc.re + c.re);
                acc.im = wrapFix(acc.im + c.im);
            end
        end
        return acc;
    endfunction

    // Forward skips the last sample and backward skips the first one
    function automatic void modelBatch(input int b);
        cplx st;
        cplx wt;
        int rf [depth];
        int rb [depth];
        for (int k = 0; k < depth; k++) begin
            rf[k] = 0;
            rb[k] = 0;
        end
        for (int ch = 0; ch < N; ch++) begin
            st = '0;
            for (int j = 0; j < depth-1; j++) begin
                st = step(lambdaF[ch], st, driveOf(ch, samples[b][j], 1'b1));
                wt = mulC(toC(weightF[ch]), st);
                rf[j+1] = wrapFix(rf[j+1] + wt.re);
            end
            // End state of the lookahead pass seeds the backward pass
            st = '0;
            for (int j = 0; j < depth-1; j++) begin
                st = step(lambdaB[ch], st, driveOf(ch, samples[b][depth-1-j], 1'b0));
            end
            wt = mulC(toC(weightB[ch]), st);
            rb[0] = wrapFix(rb[0] + wt.re);
            for (int j = 0; j < depth-1; j++) begin
                st = step(lambdaB[ch], st, driveOf(ch, samples[b][depth-1-j], 1'b0));
                wt = mulC(toC(weightB[ch]), st);
                rb[j+1] = wrapFix(rb[j+1] + wt.re);
            end
        end
        for (int k = 0; k < depth; k++) begin
            expected[b*depth+k] = wrapFix(rf[k] + rb[depth-1-k]);
        end
    endfunction

    function automatic void reportTest(input int t);
        $display("Test %0d, %s: %s with %0d errors", t, testNames[t],
                 testErrors[t] == 0 ? "passed" : "failed", testErrors[t]);
    endfunction

    // A test ends with the last batch that carries its number
    function automatic void finishBatch(input int b);
        bit later;
        later = 1'b0;
        for (int j = b+1; j < numBatches; j++) begin
            if (testOf[j] == testOf[b]) begin
                later = 1'b1;
            end
        end
        if (!later) begin
            reportTest(testOf[b]);
        end
    endfunction

    initial begin
        int cyc;
        int n;
        int testsFailed;
        bit seenReset;
        bit rose;
        bit finished;
        bit timedOut;
        done = 1'b0;
        failures = 0;
        cyc = 0;
        n = 0;
        seenReset = 1'b0;
        rose = 1'b0;
        finished = 1'b0;
        timedOut = 1'b0;
        for (int t = 0; t < 6; t++) begin
            testErrors[t] = 0;
        end
        for (int w = 0; w < 20 && loaded !== 1'b1; w++) begin
            @(posedge clkDS);
        end
        if (loaded !== 1'b1) begin
            $display("Timeout: the golden stimulus was never loaded");
            timedOut = 1'b1;
        end else begin
            for (int b = 0; b < numBatches; b++) begin
                if (useModel[b]) begin
                    modelBatch(b);
                end else begin
                    for (int k = 0; k < depth; k++) begin
                        expected[b*depth+k] = literalOut[b];
                    end
                end
            end
        end
        for (int guard = 0; guard < watchLimit && !finished && !timedOut; guard++) begin
            @(posedge clkDS);
            if (rst !== 1'b1) begin
                if (seenReset && outValid === 1'b1) begin
                    $display("Error at %0t ns: outValid high during reset", $time);
                    testErrors[1]++;
                end
                seenReset = 1'b1;
            end else begin
                if (outValid === 1'b1) begin
                    if (!rose) begin
                        rose = 1'b1;
                        if (cyc != firstValid) begin
                            $display("Error at %0t ns: first outValid at cycle %0d, expected %0d",
                                     $time, cyc, firstValid);
                            testErrors[1]++;
                        end
                        reportTest(1);
                    end
                    if (out !== fixT'(expected[n])) begin
                        $display("Error at %0t ns: batch %0d sample %0d out %0d expected %0d",
                                 $time, n/depth, n%depth, out, expected[n]);
                        testErrors[testOf[n/depth]]++;
                    end
                    n++;
                    if (n % depth == 0) begin
                        finishBatch(n/depth - 1);
                    end
                    finished = (n == numBatches*depth);
                end else if (rose) begin
                    $display("Error at %0t ns: outValid dropped after it had risen", $time);
                    testErrors[5]++;
                end
                cyc++;
            end
        end
        if (!finished && !timedOut) begin
            $display("Timeout: only %0d of %0d outputs arrived", n, numBatches*depth);
            timedOut = 1'b1;
        end
        if (!rose) begin
            testErrors[1]++;
            reportTest(1);
        end
        reportTest(5);
        testsFailed = 0;
        for (int t = 1; t < 6; t++) begin
            failures += testErrors[t];
            if (testErrors[t] != 0) begin
                testsFailed++;
            end
        end
        failures += timedOut;
        $display("Summary: 5 tests, %0d failed, %0d errors in total", testsFailed, failures);
        done = 1'b1;
    end

endmodule

//--- sim/batchFilterTb.sv
`timescale 1ns/1ps

module batchFilterTb;
    import batchPkg::*;

    localparam int N = 3;
    localparam int depth = 16;
    localparam int numBatches = 9;
    localparam int runLimit = 600;

    logic clkDS;
    logic rst;
    logic [N-1:0] ctrlIn;
    fixT out;
    logic outValid;

    // One batch per golden line
    logic [N-1:0] samples [numBatches][depth];
    logic useModel [numBatches];
    int literalOut [numBatches];
    int testOf [numBatches];
    logic loaded;
    logic done;
    int failures;

    batchFilterTop #(.N(N), .depth(depth)) batchFilterTop_inst (
        .clkDS    (clkDS),
        .rst      (rst),
        .ctrlIn   (ctrlIn),
        .out      (out),
        .outValid (outValid)
    );

    batchFilterChecker #(.N(N), .depth(depth), .numBatches(numBatches)) outChecker (
        .clkDS      (clkDS),
        .rst        (rst),
        .outValid   (outValid),
        .out        (out),
        .samples    (samples),
        .useModel   (useModel),
        .literalOut (literalOut),
        .testOf     (testOf),
        .loaded     (loaded),
        .done       (done),
        .failures   (failures)
    );

    initial begin
        clkDS = 1'b0;
        forever #10 clkDS = ~clkDS;
    end

    // Lines starting with # are comments and sample 0 is the leftmost hex digit
    task automatic loadGolden(output bit ok);
        int fd;
        int got;
        int nb;
        int t;
        logic [63:0] words;
        string line;
        string expStr;
        ok = 1'b0;
        nb = 0;
        fd = $fopen("sim/batchGolden.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && nb < numBatches) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%d %h %s", t, words, expStr);
                if (got == 3) begin
                    testOf[nb] = t;
                    useModel[nb] = (expStr == "m");
                    literalOut[nb] = expStr.atoi();
                    for (int i = 0; i < depth; i++) begin
                        samples[nb][i] = words[4*(depth-1-i) +: N];
                    end
                    nb++;
                end
            end
        end
        $fclose(fd);
        ok = (nb == numBatches);
    endtask

    initial begin
        bit ok;
        rst <= 1'b0;
        ctrlIn <= '0;
        loaded = 1'b0;
        loadGolden(ok);
        if (!ok) begin
            $display("Could not read a complete golden file");
            $display("Simulation failed");
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clkDS);
            rst <= 1'b1;
            ctrlIn <= samples[0][0];
            // Zeros after the last batch flush the pipeline
            for (int c = 1; c < runLimit && !done; c++) begin
                @(posedge clkDS);
                if (c < numBatches*depth) begin
                    ctrlIn <= samples[c/depth][c%depth];
                end else begin
                    ctrlIn <= '0;
                end
            end
            if (!done) begin
                $display("Timeout: the checker did not finish within %0d cycles", runLimit);
                $display("Simulation failed");
            end else if (failures == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

//--- sim/batchGolden.txt
# test, 16 control words as hex digits with sample 0 leftmost, expected output
# expected is one value for every output of the batch, or m for the fixed-point model
2 0000000000000000 0
2 0000000000000000 0
3 0000000100000000 m
3 0000000000000000 0
4 3516240713562047 m
4 7042615305173624 m
4 1602753421076530 m
4 6275031417302651 m
2 0000000000000000 0
